/* design/rback_pkg.sv */
// shared widths, address windows and bus structs of the readback block
// windows are compared as ((addr ^ base) & mask) == 0, so bits outside the mask are ignored
// control and status read windows must stay disjoint, the combiner relies on it
package rback_pkg;

    localparam int wr_addr_bits = 14; // parallel command word address
    localparam int rd_addr_bits = 14; // burst start address on the read side
    localparam int rback_depth  = 11; // shadow memory, 2048 words
    localparam int status_depth = 4;  // status file, 16 words

    // write window captured into the shadow memory
    localparam logic [wr_addr_bits-1:0] control_addr      = 14'h0000;
    localparam logic [wr_addr_bits-1:0] control_addr_mask = 14'h3800;

    // read windows, one per store
    localparam logic [rd_addr_bits-1:0] control_rback_addr = 14'h0000;
    localparam logic [rd_addr_bits-1:0] control_rback_mask = 14'h3800;
    localparam logic [rd_addr_bits-1:0] status_rback_addr  = 14'h0800;
    localparam logic [rd_addr_bits-1:0] status_rback_mask  = 14'h3800;

    // one parallel command write
    typedef struct packed {
        logic [wr_addr_bits-1:0] waddr; // word address
        logic [31:0]             data;
        logic                    stb;   // one cycle per write
    } par_wr_t;

    // one status update pushed by the device
    typedef struct packed {
        logic [status_depth-1:0] addr;  // status file entry
        logic [31:0]             data;
        logic                    stb;   // writes at this edge
    } status_wr_t;

    // bus side read request
    typedef struct packed {
        logic [rd_addr_bits-1:0] pre_araddr;  // valid with start_burst
        logic                    start_burst; // one cycle pulse
        logic [rback_depth-1:0]  raddr;       // word index, valid with ren
        logic                    ren;         // one per word
    } rd_req_t;

    // read reply of one store
    typedef struct packed {
        logic [31:0] rdata;
        logic        selected; // this store owns the current burst
    } rd_rsp_t;

endpackage

/* design/cmd_readback.sv */
// shadow memory of control writes, 2048 words, no reset on the array
// a write lands one cycle after its strobe, a read returns data two edges after ren
// the reader has no back-pressure and must take the word when it appears
`timescale 1ns/1ps

module cmd_readback (
    input  logic               mclk,
    input  logic               axi_clk, // async reset, active high
    input  rback_pkg::par_wr_t par_wr,
    input  rback_pkg::rd_req_t rd_req,
    output rback_pkg::rd_rsp_t rsp
);

    logic [31:0] shadow_mem [0:2**rback_pkg::rback_depth-1]; // 2 brams worth

    logic                              we_w;     // write hits control window
    logic                              we_r;     // registered strobe
    logic [rback_pkg::rback_depth-1:0] waddr_r;  // registered memory index
    logic [31:0]                       wdata_r;

    logic        select_w;  // burst start address in our read window
    logic        select_r;  // held until next start_burst
    logic        select_d;  // aligned with the output stage
    logic        ren_d;     // output stage enable
    logic        rd;
    logic        regen;
    logic [31:0] rdata_s1;  // first read stage
    logic [31:0] rdata_s2;  // output stage

    assign we_w = par_wr.stb &&
        (((par_wr.waddr ^ rback_pkg::control_addr) & rback_pkg::control_addr_mask) == '0);
    assign select_w =
        (((rd_req.pre_araddr ^ rback_pkg::control_rback_addr) &
          rback_pkg::control_rback_mask) == '0);

    assign rd    = rd_req.ren && select_r; // only read while selected
    assign regen = ren_d && select_d;

    // write side, strobe stage
    always_ff @(posedge mclk or posedge axi_clk) begin
        if (axi_clk) begin
            we_r <= 1'b0;
        end else begin
            we_r <= we_w;
        end
    end

    always_ff @(posedge mclk) begin
        if (we_w) begin
            waddr_r <= par_wr.waddr[rback_pkg::rback_depth-1:0]; // low bits index the array
            wdata_r <= par_wr.data;
        end
        if (we_r) begin
            shadow_mem[waddr_r] <= wdata_r; // one cycle after the bus write
        end
    end

    // read side, select and enable tracking
    always_ff @(posedge mclk or posedge axi_clk) begin
        if (axi_clk) begin
            select_r <= 1'b0;
            select_d <= 1'b0;
            ren_d    <= 1'b0;
        end else begin
            if (rd_req.start_burst) begin
                select_r <= select_w; // latched once per burst
            end
            select_d <= select_r;
            ren_d    <= rd_req.ren;
        end
    end

    // two stage read data, payload only
    always_ff @(posedge mclk) begin
        if (rd) begin
            rdata_s1 <= shadow_mem[rd_req.raddr];
        end
        if (regen) begin
            rdata_s2 <= rdata_s1;
        end
    end

    assign rsp.rdata    = rdata_s2;
    assign rsp.selected = select_r;

endmodule

/* design/status_capture.sv */
// 16 entry status file written directly by device strobes
// an entry is readable the cycle after its strobe edge
// read path matches the shadow memory, only the low raddr bits are used
`timescale 1ns/1ps

module status_capture (
    input  logic                  mclk,
    input  logic                  axi_clk, // async reset, active high
    input  rback_pkg::status_wr_t status_wr,
    input  rback_pkg::rd_req_t    rd_req,
    output rback_pkg::rd_rsp_t    rsp
);

    logic [31:0] status_mem [0:2**rback_pkg::status_depth-1]; // latest word per entry

    logic                               select_w; // burst start in status window
    logic                               select_r;
    logic                               select_d;
    logic                               ren_d;
    logic                               rd;
    logic                               regen;
    logic [rback_pkg::status_depth-1:0] rindex;   // status entry being read
    logic [31:0]                        rdata_s1;
    logic [31:0]                        rdata_s2;

    assign select_w =
        (((rd_req.pre_araddr ^ rback_pkg::status_rback_addr) &
          rback_pkg::status_rback_mask) == '0);

    assign rindex = rd_req.raddr[rback_pkg::status_depth-1:0];
    assign rd     = rd_req.ren && select_r;
    assign regen  = ren_d && select_d;

    // device side, no staging register
    always_ff @(posedge mclk) begin
        if (status_wr.stb) begin
            status_mem[status_wr.addr] <= status_wr.data; // overwrite, no history kept
        end
    end

    always_ff @(posedge mclk or posedge axi_clk) begin
        if (axi_clk) begin
            select_r <= 1'b0;
            select_d <= 1'b0;
            ren_d    <= 1'b0;
        end else begin
            if (rd_req.start_burst) begin
                select_r <= select_w;
            end
            select_d <= select_r; // follows output stage
            ren_d    <= rd_req.ren;
        end
    end

    always_ff @(posedge mclk) begin
        if (rd) begin
            rdata_s1 <= status_mem[rindex];
        end
        if (regen) begin
            rdata_s2 <= rdata_s1; // holds until next enabled read
        end
    end

    assign rsp.rdata    = rdata_s2;
    assign rsp.selected = select_r;

endmodule

/* design/rback_merge.sv */
// merges the two store replies, purely combinational
// windows are disjoint so at most one flag is high, control wins if both ever are
// rdata is forced to zero while nothing is selected
`timescale 1ns/1ps

module rback_merge (
    input  rback_pkg::rd_rsp_t ctl_rsp,  // shadow memory reply
    input  rback_pkg::rd_rsp_t sts_rsp,  // status file reply
    output logic [31:0]        rdata,
    output logic               selected
);

    logic ctl_sel;
    logic sts_sel;

    assign ctl_sel = ctl_rsp.selected;
    assign sts_sel = sts_rsp.selected;

    // any store owning the burst
    assign selected = ctl_sel | sts_sel;

    always_comb begin
        if (ctl_sel) begin
            rdata = ctl_rsp.rdata;
        end else if (sts_sel) begin
            rdata = sts_rsp.rdata;
        end else begin
            rdata = '0; // no stale store data leaks out
        end
    end

endmodule

/* design/rback_top.sv */
// top of the readback block, single clock mclk
// axi_clk is the async active high reset despite its name
// read data appears two edges after ren, with no back-pressure
`timescale 1ns/1ps

module rback_top (
    input  logic                  mclk,
    input  logic                  axi_clk,
    input  rback_pkg::par_wr_t    par_wr,    // command bus writes
    input  rback_pkg::status_wr_t status_wr, // device status pushes
    input  rback_pkg::rd_req_t    rd_req,    // bus side reads
    output logic [31:0]           rdata,
    output logic                  selected
);

    rback_pkg::rd_rsp_t ctl_rsp; // shadow memory reply
    rback_pkg::rd_rsp_t sts_rsp; // status file reply

    cmd_readback cmd_readback_i (
        .mclk    (mclk),
        .axi_clk (axi_clk),
        .par_wr  (par_wr),
        .rd_req  (rd_req),
        .rsp     (ctl_rsp)
    );

    status_capture status_capture_i (
        .mclk      (mclk),
        .axi_clk   (axi_clk),
        .status_wr (status_wr),
        .rd_req    (rd_req),
        .rsp       (sts_rsp)
    );

    rback_merge rback_merge_i (
        .ctl_rsp  (ctl_rsp),
        .sts_rsp  (sts_rsp),
        .rdata    (rdata),
        .selected (selected)
    );

endmodule

/* testbench/rback_checker.sv */
// concurrent checks on the merged read path of rback_top, attached by bind below
// rules are disabled while axi_clk holds the design in reset
`timescale 1ns/1ps

module rback_checker (
    input logic        mclk,
    input logic        axi_clk,
    input logic        start_burst,
    input logic        ctl_sel,   // shadow memory owns the burst
    input logic        sts_sel,   // status file owns the burst
    input logic        selected,
    input logic [31:0] rdata
);

    logic seen_start; // a burst has started since reset
    int   fail_cnt = 0;

    always_ff @(posedge mclk or posedge axi_clk) begin
        if (axi_clk) begin
            seen_start <= 1'b0;
        end else if (start_burst) begin
            seen_start <= 1'b1;
        end
    end

    idle_until_burst: assert property (
        @(posedge mclk) disable iff (axi_clk) !seen_start |-> !selected
    ) else begin
        fail_cnt++;
        $error("selected went high before the first burst start");
    end

    one_store_only: assert property (
        @(posedge mclk) disable iff (axi_clk) !(ctl_sel && sts_sel)
    ) else begin
        fail_cnt++;
        $error("both stores selected at once");
    end

    zero_when_idle: assert property (
        @(posedge mclk) disable iff (axi_clk) !selected |-> (rdata == 32'h0)
    ) else begin
        fail_cnt++;
        $error("rdata nonzero while nothing is selected");
    end

endmodule

bind rback_top rback_checker checker_i (
    .mclk        (mclk),
    .axi_clk     (axi_clk),
    .start_burst (rd_req.start_burst),
    .ctl_sel     (ctl_rsp.selected),
    .sts_sel     (sts_rsp.selected),
    .selected    (selected),
    .rdata       (rdata)
);

/* testbench/rback_tb.sv */
// testbench for rback_top, mclk only, axi_clk is the async active high reset
// stimulus from a 32-bit fibonacci lfsr, checked against a cycle model of both stores
// words never written are not compared, data registers carry no reset value
`timescale 1ns/1ps

module rback_tb;

    localparam int reset_cycles   = 5;
    localparam int fill_cycles    = 64;
    localparam int burst_len      = 16;
    localparam int drain_cycles   = 3;
    localparam int test_cycles    = reset_cycles + 1 + fill_cycles +
                                    4 * (1 + burst_len + drain_cycles); // fill plus four bursts
    localparam int timeout_cycles = test_cycles + 20;

    logic                  mclk;
    logic                  axi_clk;
    rback_pkg::par_wr_t    par_wr;
    rback_pkg::status_wr_t status_wr;
    rback_pkg::rd_req_t    rd_req;
    logic [31:0]           rdata;
    logic                  selected;

    logic [31:0]           lfsr = 32'h075f8026;
    int                    cyc;             // edge that samples the current drive
    int                    wd_cnt = 0;
    logic [31:0]           ctl_model [0:2047];
    bit                    ctl_known [0:2047];
    logic [31:0]           sts_model [0:15];
    bit                    sts_known [0:15];
    rback_pkg::par_wr_t    ctl_pend_a;      // write from two cycles back
    rback_pkg::par_wr_t    ctl_pend_b;      // write from last cycle
    rback_pkg::status_wr_t sts_pend;        // status write from last cycle
    int                    exp_store;       // 0 none, 1 control, 2 status
    logic [10:0]           idx_list [$];    // control indices written inside the window
    int                    due_q [$];       // cycle at which rdata is compared
    logic [31:0]           exp_q [$];
    bit                    known_q [$];

    initial begin
        mclk = 1'b0;
        forever #5 mclk = ~mclk;
    end

    rback_top dut_i (
        .mclk      (mclk),
        .axi_clk   (axi_clk),
        .par_wr    (par_wr),
        .status_wr (status_wr),
        .rd_req    (rd_req),
        .rdata     (rdata),
        .selected  (selected)
    );

    always @(posedge mclk) begin
        wd_cnt <= wd_cnt + 1;
        if (wd_cnt >= timeout_cycles) begin
            $display("timeout, run did not finish within %0d cycles", timeout_cycles);
            $display("RESULT: FAIL");
            $fatal(1, "watchdog expired");
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // bits 13:11 pick the store, both windows use mask 3800
    function automatic int window_of(input logic [13:0] addr);
        if (addr[13:11] == 3'd0) return 1;
        if (addr[13:11] == 3'd1) return 2;
        return 0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s at cycle %0d: got 0x%08h, expected 0x%08h", name, cyc, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic rback_pkg::par_wr_t rand_ctl_write();
        rback_pkg::par_wr_t pw;
        logic [2:0]         upper;
        logic [10:0]        idx;
        upper = 3'(rand_bits(3));
        if (rand_bits(2) != 0) upper = 3'd0; // most writes land in the window
        if (idx_list.size() > 0 && rand_bits(1) != 0) begin
            idx = idx_list[rand_bits(8) % idx_list.size()]; // revisit a written word
        end else begin
            idx = 11'(rand_bits(11));
        end
        pw.waddr = {upper, idx};
        pw.data  = rand_bits(32);
        pw.stb   = (rand_bits(2) != 0);
        if (pw.stb && upper == 3'd0) idx_list.push_back(idx);
        return pw;
    endfunction

    function automatic rback_pkg::status_wr_t rand_sts_write();
        rback_pkg::status_wr_t sw;
        sw.addr = 4'(rand_bits(4));
        sw.data = rand_bits(32);
        sw.stb  = (rand_bits(1) != 0);
        return sw;
    endfunction

    // check what the last edge produced, drive the next inputs, advance the model
    task automatic drive_cycle(input rback_pkg::par_wr_t pw, input rback_pkg::status_wr_t sw,
                               input rback_pkg::rd_req_t rq);
        @(negedge mclk);
        cyc++;
        if (dut_i.checker_i.fail_cnt != 0) begin
            $display("a read path assertion failed before cycle %0d", cyc);
            $display("RESULT: FAIL");
            $fatal(1, "assertion failure in the bound checker");
        end
        while (due_q.size() > 0 && due_q[0] == cyc) begin
            if (known_q[0]) begin
                check_value("rdata", rdata, exp_q[0]);
            end
            void'(due_q.pop_front());
            void'(exp_q.pop_front());
            void'(known_q.pop_front());
        end
        check_value("selected", 32'(selected), 32'(exp_store != 0));
        if (exp_store == 0) begin
            check_value("rdata", rdata, 32'h0); // merge outputs zero when idle
        end
        par_wr    = pw;
        status_wr = sw;
        rd_req    = rq;
        if (ctl_pend_a.stb && window_of(ctl_pend_a.waddr) == 1) begin
            ctl_model[ctl_pend_a.waddr[10:0]] = ctl_pend_a.data; // memory edge of that write
            ctl_known[ctl_pend_a.waddr[10:0]] = 1'b1;
        end
        ctl_pend_a = ctl_pend_b;
        ctl_pend_b = pw;
        if (sts_pend.stb) begin
            sts_model[sts_pend.addr] = sts_pend.data;
            sts_known[sts_pend.addr] = 1'b1;
        end
        sts_pend = sw;
        if (rq.ren && exp_store != 0) begin
            due_q.push_back(cyc + 2); // output stage loads one edge after ren
            if (exp_store == 1) begin
                exp_q.push_back(ctl_model[rq.raddr]);
                known_q.push_back(ctl_known[rq.raddr]);
            end else begin
                exp_q.push_back(sts_model[rq.raddr[3:0]]);
                known_q.push_back(sts_known[rq.raddr[3:0]]);
            end
        end
        if (rq.start_burst) exp_store = window_of(rq.pre_araddr);
    endtask

    task automatic fill_stores();
        rback_pkg::status_wr_t sw;
        for (int i = 0; i < fill_cycles; i++) begin
            sw = rand_sts_write();
            if (i < 16) begin
                sw.addr = 4'(i); // every status entry gets a first value
                sw.stb  = 1'b1;
            end
            drive_cycle(rand_ctl_write(), sw, '0);
        end
    endtask

    // back-to-back burst, status writes keep arriving during a status burst
    task automatic read_burst(input logic [2:0] win);
        rback_pkg::rd_req_t    rq;
        rback_pkg::status_wr_t sw;
        rq             = '0;
        rq.start_burst = 1'b1;
        rq.pre_araddr  = {win, 11'(rand_bits(11))};
        drive_cycle('0, '0, rq);
        for (int i = 0; i < burst_len; i++) begin
            rq     = '0;
            rq.ren = 1'b1;
            if (win == 3'd0) begin
                rq.raddr = idx_list[rand_bits(8) % idx_list.size()];
            end else begin
                rq.raddr = 11'(rand_bits(11));
            end
            sw = (win == 3'd1) ? rand_sts_write() : rback_pkg::status_wr_t'('0);
            drive_cycle('0, sw, rq);
        end
        repeat (drain_cycles) drive_cycle('0, '0, '0);
    endtask

    // every cycle writes a word and reads the one written two cycles earlier
    task automatic write_then_read();
        rback_pkg::par_wr_t pw;
        rback_pkg::rd_req_t rq;
        logic [10:0]        hist [$];
        rq             = '0;
        rq.start_burst = 1'b1;
        rq.pre_araddr  = {3'd0, 11'(rand_bits(11))};
        drive_cycle('0, '0, rq);
        for (int i = 0; i < burst_len; i++) begin
            pw       = '0;
            pw.stb   = 1'b1;
            pw.waddr = {3'd0, idx_list[rand_bits(8) % idx_list.size()]};
            pw.data  = rand_bits(32);
            rq       = '0;
            rq.ren   = 1'b1;
            rq.raddr = (hist.size() >= 2) ? hist[hist.size()-2] : idx_list[0];
            hist.push_back(pw.waddr[10:0]);
            drive_cycle(pw, '0, rq);
        end
        repeat (drain_cycles) drive_cycle('0, '0, '0);
    endtask

    initial begin
        axi_clk    = 1'b1;
        par_wr     = '0;
        status_wr  = '0;
        rd_req     = '0;
        ctl_pend_a = '0;
        ctl_pend_b = '0;
        sts_pend   = '0;
        cyc        = 0;
        exp_store  = 0;
        repeat (reset_cycles) @(posedge mclk);
        @(negedge mclk);
        axi_clk = 1'b0;
        fill_stores();
        read_burst(3'd0);  // control window, includes filtered writes
        write_then_read();
        read_burst(3'd1);  // status window
        read_burst(3'd5);  // outside both windows
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* sim.f */
design/rback_pkg.sv
design/cmd_readback.sv
design/status_capture.sv
design/rback_merge.sv
design/rback_top.sv
testbench/rback_checker.sv
testbench/rback_tb.sv

/* Makefile */
# Verilator build and run of the readback block testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= rback_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
